// File: src/user_pkg.sv
//--------------------------------------------------------------------------
// User domain package
// Address map, NeoPixel register offsets, ROM contents and bus widths
//--------------------------------------------------------------------------

`default_nettype none

package user_pkg;

  // Bus widths
  localparam int unsigned AddrWidth = 32;
  localparam int unsigned DataWidth = 32;

  //--------------------------------------------------------------------------
  // Address map
  //--------------------------------------------------------------------------

  // Constant table region
  localparam logic [AddrWidth-1:0] UserRomBase      = 32'h2000_0000;
  localparam logic [AddrWidth-1:0] UserRomSize      = 32'h0000_1000;

  // LED driver region
  localparam logic [AddrWidth-1:0] UserNeopixelBase = 32'h2000_1000;
  localparam logic [AddrWidth-1:0] UserNeopixelSize = 32'h0000_1000;

  // NeoPixel register offsets inside its region
  localparam logic [AddrWidth-1:0] NpCtrlOffset   = 32'h0000_0000;
  localparam logic [AddrWidth-1:0] NpStatusOffset = 32'h0000_0004;
  localparam logic [AddrWidth-1:0] NpDataOffset   = 32'h0000_0008;
  localparam logic [AddrWidth-1:0] NpThreshOffset = 32'h0000_000C;

  //--------------------------------------------------------------------------
  // ROM contents
  //--------------------------------------------------------------------------

  localparam int unsigned RomWords = 8;

  // Index 0 first
  localparam logic [0:RomWords-1][DataWidth-1:0] RomTable = '{
    32'h0000_0001,
    32'h1234_5678,
    32'hDEAD_BEEF,
    32'hCAFE_F00D,
    32'h0F0F_0F0F,
    32'hA5A5_5A5A,
    32'h8000_0000,
    32'hFFFF_FFFF
  };

  // Read data returned for unmapped addresses
  localparam logic [DataWidth-1:0] ErrRspData = 32'hBADCAB1E;

  // Interrupt vector width towards the core
  localparam int unsigned NumExternalIrqs = 4;

  // One GRB pixel, sent MSB first
  localparam int unsigned PixelWidth = 24;

endpackage

`default_nettype wire

// File: src/user_sbr_demux.sv
//--------------------------------------------------------------------------
// User subordinate demultiplexer
// Routes requests by address, answers unmapped ones, merges responses
//--------------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module user_sbr_demux (
  input  logic                           clk_i,
  input  logic                           rst_n_i,
  // Outside subordinate port
  input  logic                           sbr_req_i,
  output logic                           sbr_gnt_o,
  input  logic [user_pkg::AddrWidth-1:0] sbr_addr_i,
  output logic                           sbr_rvalid_o,
  output logic [user_pkg::DataWidth-1:0] sbr_rdata_o,
  output logic                           sbr_err_o,
  // ROM subordinate
  output logic                           rom_req_o,
  input  logic                           rom_gnt_i,
  input  logic                           rom_rvalid_i,
  input  logic [user_pkg::DataWidth-1:0] rom_rdata_i,
  // NeoPixel subordinate
  output logic                           np_req_o,
  input  logic                           np_gnt_i,
  input  logic                           np_rvalid_i,
  input  logic [user_pkg::DataWidth-1:0] np_rdata_i
);

  typedef enum logic [1:0] {
    TgtErr,
    TgtRom,
    TgtNp
  } tgt_e;

  tgt_e                         sel;
  tgt_e                         rsp_tgt_q;
  logic                         transfer;
  logic                         err_pending_q;
  logic [user_pkg::AddrWidth-1:0] rom_off;
  logic [user_pkg::AddrWidth-1:0] np_off;

  //--------------------------------------------------------------------------
  // Address decode
  //--------------------------------------------------------------------------

  // Below-base addresses wrap to large offsets and miss
  assign rom_off = sbr_addr_i - user_pkg::UserRomBase;
  assign np_off  = sbr_addr_i - user_pkg::UserNeopixelBase;

  always_comb begin
    if (rom_off < user_pkg::UserRomSize) begin
      sel = TgtRom;
    end else if (np_off < user_pkg::UserNeopixelSize) begin
      sel = TgtNp;
    end else begin
      sel = TgtErr;
    end
  end

  // Request goes to the selected target only
  assign rom_req_o = sbr_req_i && (sel == TgtRom);
  assign np_req_o  = sbr_req_i && (sel == TgtNp);

  // Error target always grants
  always_comb begin
    case (sel)
      TgtRom:  sbr_gnt_o = rom_gnt_i;
      TgtNp:   sbr_gnt_o = np_gnt_i;
      default: sbr_gnt_o = 1'b1;
    endcase
  end

  assign transfer = sbr_req_i && sbr_gnt_o;

  // Remember who answers next cycle
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rsp_tgt_q     <= TgtErr;
      err_pending_q <= 1'b0;
    end else begin
      err_pending_q <= transfer && (sel == TgtErr);
      if (transfer) begin
        rsp_tgt_q <= sel;
      end
    end
  end

  //--------------------------------------------------------------------------
  // Response merge
  //--------------------------------------------------------------------------

  always_comb begin
    case (rsp_tgt_q)
      TgtRom: begin
        sbr_rvalid_o = rom_rvalid_i;
        sbr_rdata_o  = rom_rdata_i;
      end
      TgtNp: begin
        sbr_rvalid_o = np_rvalid_i;
        sbr_rdata_o  = np_rdata_i;
      end
      default: begin
        sbr_rvalid_o = err_pending_q;
        sbr_rdata_o  = user_pkg::ErrRspData;
      end
    endcase
  end

  // Only the error target flags err
  assign sbr_err_o = err_pending_q;

endmodule

`default_nettype wire

// File: src/user_rom.sv
//--------------------------------------------------------------------------
// User ROM subordinate
// Returns words of the constant table, one cycle after each transfer
//--------------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module user_rom (
  input  logic                           clk_i,
  input  logic                           rst_n_i,
  input  logic                           req_i,
  input  logic [user_pkg::AddrWidth-1:0] addr_i,
  output logic                           gnt_o,
  output logic                           rvalid_o,
  output logic [user_pkg::DataWidth-1:0] rdata_o
);

  localparam int unsigned IdxWidth = $clog2(user_pkg::RomWords);

  logic [IdxWidth-1:0]            word_idx;
  logic                           rvalid_q;
  logic [user_pkg::DataWidth-1:0] rdata_q;

  // Word index from the byte address
  assign word_idx = addr_i[IdxWidth+1:2];

  // Never stalls
  assign gnt_o = 1'b1;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= req_i;
    end
  end

  // Writes fetch the same word and change nothing
  always_ff @(posedge clk_i) begin
    if (req_i) begin
      rdata_q <= user_pkg::RomTable[word_idx];
    end
  end

  assign rvalid_o = rvalid_q;
  assign rdata_o  = rdata_q;

endmodule

`default_nettype wire

// File: src/pixel_fifo.sv
//--------------------------------------------------------------------------
// Pixel FIFO
// Synchronous circular buffer with fill level
//--------------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module pixel_fifo #(
  parameter int unsigned Width = 24,
  parameter int unsigned Depth = 8
) (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  logic                       push_i,
  input  logic [Width-1:0]           wdata_i,
  input  logic                       pop_i,
  output logic [Width-1:0]           rdata_o,
  output logic                       empty_o,
  output logic                       full_o,
  output logic [$clog2(Depth+1)-1:0] level_o
);

  localparam int unsigned PtrWidth = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int unsigned LvlWidth = $clog2(Depth + 1);

  logic [Width-1:0]    mem_q [Depth];
  logic [PtrWidth-1:0] wr_ptr_q;
  logic [PtrWidth-1:0] rd_ptr_q;
  logic [LvlWidth-1:0] level_q;
  logic                do_push;
  logic                do_pop;

  // Drop push on full and pop on empty
  assign do_push = push_i && !full_o;
  assign do_pop  = pop_i && !empty_o;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      level_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == PtrWidth'(Depth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == PtrWidth'(Depth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      // Level holds when both happen
      if (do_push && !do_pop) begin
        level_q <= level_q + 1'b1;
      end else if (do_pop && !do_push) begin
        level_q <= level_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= wdata_i;
    end
  end

  // Head word visible without a read strobe
  assign rdata_o = mem_q[rd_ptr_q];
  assign empty_o = (level_q == '0);
  assign full_o  = (level_q == LvlWidth'(Depth));
  assign level_o = level_q;

endmodule

`default_nettype wire

// File: src/neopixel_serializer.sv
//--------------------------------------------------------------------------
// NeoPixel serializer
// WS2812 bit timing for pixel words, with a low latch gap at the end
//--------------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module neopixel_serializer #(
  parameter int unsigned PixelWidth  = 24,
  parameter int unsigned BitCycles   = 12,
  parameter int unsigned T0hCycles   = 4,
  parameter int unsigned T1hCycles   = 8,
  parameter int unsigned ResetCycles = 40
) (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  enable_i,
  input  logic                  empty_i,
  input  logic [PixelWidth-1:0] pixel_i,
  output logic                  pop_o,
  output logic                  busy_o,
  output logic                  data_o
);

  // Cycle counter covers both a bit period and the latch gap
  localparam int unsigned CntMax   = (ResetCycles > BitCycles) ? ResetCycles : BitCycles;
  localparam int unsigned CntWidth = $clog2(CntMax);
  localparam int unsigned BitWidth = $clog2(PixelWidth);

  typedef enum logic [1:0] {
    Idle,
    Send,
    Latch
  } state_e;

  state_e                state_q;
  logic [CntWidth-1:0]   cyc_q;
  logic [BitWidth-1:0]   bit_q;
  logic [PixelWidth-1:0] shift_q;
  logic                  data_q;
  logic                  last_cyc;
  logic                  last_bit;
  logic                  load;
  logic                  high;

  assign last_cyc = (cyc_q == CntWidth'(BitCycles - 1));
  assign last_bit = (bit_q == BitWidth'(PixelWidth - 1));

  // Take a new pixel from idle or straight after the last bit
  assign load = enable_i && !empty_i &&
                ((state_q == Idle) || ((state_q == Send) && last_cyc && last_bit));

  // High phase length follows the current MSB
  assign high = (state_q == Send) &&
                (cyc_q < (shift_q[PixelWidth-1] ? CntWidth'(T1hCycles)
                                                : CntWidth'(T0hCycles)));

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= Idle;
      cyc_q   <= '0;
      bit_q   <= '0;
      data_q  <= 1'b0;
    end else begin
      data_q <= high;
      case (state_q)
        Idle: begin
          if (load) begin
            state_q <= Send;
            cyc_q   <= '0;
            bit_q   <= '0;
          end
        end
        Send: begin
          if (last_cyc) begin
            cyc_q <= '0;
            if (last_bit) begin
              bit_q <= '0;
              // No next pixel so start the latch gap
              if (!load) begin
                state_q <= Latch;
              end
            end else begin
              bit_q <= bit_q + 1'b1;
            end
          end else begin
            cyc_q <= cyc_q + 1'b1;
          end
        end
        Latch: begin
          if (cyc_q == CntWidth'(ResetCycles - 1)) begin
            state_q <= Idle;
            cyc_q   <= '0;
          end else begin
            cyc_q <= cyc_q + 1'b1;
          end
        end
        default: begin
          state_q <= Idle;
        end
      endcase
    end
  end

  // Pixel shifter, MSB goes out first
  always_ff @(posedge clk_i) begin
    if (load) begin
      shift_q <= pixel_i;
    end else if ((state_q == Send) && last_cyc) begin
      shift_q <= shift_q << 1;
    end
  end

  assign pop_o  = load;
  assign busy_o = (state_q != Idle);
  assign data_o = data_q;

endmodule

`default_nettype wire

// File: src/neopixel.sv
//--------------------------------------------------------------------------
// NeoPixel subordinate
// Register file and pixel FIFO in front of the WS2812 serializer
//--------------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module neopixel #(
  parameter int unsigned FifoDepth   = 8,
  parameter int unsigned BitCycles   = 12,
  parameter int unsigned T0hCycles   = 4,
  parameter int unsigned T1hCycles   = 8,
  parameter int unsigned ResetCycles = 40
) (
  input  logic                           clk_i,
  input  logic                           rst_n_i,
  input  logic                           req_i,
  input  logic                           we_i,
  input  logic [user_pkg::AddrWidth-1:0] addr_i,
  input  logic [user_pkg::DataWidth-1:0] wdata_i,
  output logic                           gnt_o,
  output logic                           rvalid_o,
  output logic [user_pkg::DataWidth-1:0] rdata_o,
  output logic                           irq_o,
  output logic                           data_o
);

  localparam int unsigned LvlWidth = $clog2(FifoDepth + 1);

  logic [user_pkg::AddrWidth-1:0]  reg_off;
  logic                            is_data;
  logic                            transfer;
  logic                            reg_write;
  logic                            push;
  logic                            pop;
  logic [user_pkg::PixelWidth-1:0] fifo_head;
  logic                            fifo_empty;
  logic                            fifo_full;
  logic [LvlWidth-1:0]             fifo_level;
  logic                            busy;
  logic                            enable_q;
  logic [7:0]                      thresh_q;
  logic                            irq_q;
  logic                            rvalid_q;
  logic [user_pkg::DataWidth-1:0]  rdata_q;
  logic [user_pkg::DataWidth-1:0]  rdata_d;

  //--------------------------------------------------------------------------
  // Bus side
  //--------------------------------------------------------------------------

  // Offset within the 4 KiB region
  assign reg_off = addr_i & (user_pkg::UserNeopixelSize - 1);
  assign is_data = (reg_off == user_pkg::NpDataOffset);

  // Stall a pixel write until the FIFO has room
  assign gnt_o     = !(we_i && is_data && fifo_full);
  assign transfer  = req_i && gnt_o;
  assign reg_write = transfer && we_i;
  assign push      = reg_write && is_data;

  // Control registers
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      enable_q <= 1'b0;
      thresh_q <= '0;
    end else if (reg_write) begin
      if (reg_off == user_pkg::NpCtrlOffset) begin
        enable_q <= wdata_i[0];
      end
      if (reg_off == user_pkg::NpThreshOffset) begin
        thresh_q <= wdata_i[7:0];
      end
    end
  end

  // Read mux, DATA and unknown offsets read as zero
  always_comb begin
    rdata_d = '0;
    case (reg_off)
      user_pkg::NpCtrlOffset: begin
        rdata_d[0] = enable_q;
      end
      user_pkg::NpStatusOffset: begin
        rdata_d[7:0] = 8'(fifo_level);
        rdata_d[8]   = fifo_empty;
        rdata_d[9]   = fifo_full;
        rdata_d[10]  = busy;
      end
      user_pkg::NpThreshOffset: begin
        rdata_d[7:0] = thresh_q;
      end
      default: begin
        rdata_d = '0;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rvalid_q <= 1'b0;
      irq_q    <= 1'b0;
    end else begin
      rvalid_q <= transfer;
      // Low-level interrupt, only while running
      irq_q    <= enable_q && (8'(fifo_level) <= thresh_q);
    end
  end

  always_ff @(posedge clk_i) begin
    if (transfer) begin
      rdata_q <= rdata_d;
    end
  end

  assign rvalid_o = rvalid_q;
  assign rdata_o  = rdata_q;
  assign irq_o    = irq_q;

  //--------------------------------------------------------------------------
  // Pixel path
  //--------------------------------------------------------------------------

  pixel_fifo #(
    .Width ( user_pkg::PixelWidth ),
    .Depth ( FifoDepth            )
  ) i_pixel_fifo (
    .clk_i,
    .rst_n_i,
    .push_i  ( push                              ),
    .wdata_i ( wdata_i[user_pkg::PixelWidth-1:0] ),
    .pop_i   ( pop                               ),
    .rdata_o ( fifo_head                         ),
    .empty_o ( fifo_empty                        ),
    .full_o  ( fifo_full                         ),
    .level_o ( fifo_level                        )
  );

  neopixel_serializer #(
    .PixelWidth  ( user_pkg::PixelWidth ),
    .BitCycles   ( BitCycles            ),
    .T0hCycles   ( T0hCycles            ),
    .T1hCycles   ( T1hCycles            ),
    .ResetCycles ( ResetCycles          )
  ) i_serializer (
    .clk_i,
    .rst_n_i,
    .enable_i ( enable_q   ),
    .empty_i  ( fifo_empty ),
    .pixel_i  ( fifo_head  ),
    .pop_o    ( pop        ),
    .busy_o   ( busy       ),
    .data_o   ( data_o     )
  );

endmodule

`default_nettype wire

// File: src/user_domain.sv
//--------------------------------------------------------------------------
// User domain top
// Address demux with ROM and NeoPixel subordinates behind one bus port
//--------------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module user_domain #(
  parameter int unsigned FifoDepth   = 8,
  parameter int unsigned BitCycles   = 12,
  parameter int unsigned T0hCycles   = 4,
  parameter int unsigned T1hCycles   = 8,
  parameter int unsigned ResetCycles = 40
) (
  input  logic                                 clk_i,
  input  logic                                 rst_n_i,
  // Subordinate bus port
  input  logic                                 sbr_req_i,
  input  logic                                 sbr_we_i,
  input  logic [user_pkg::AddrWidth-1:0]       sbr_addr_i,
  input  logic [user_pkg::DataWidth-1:0]       sbr_wdata_i,
  output logic                                 sbr_gnt_o,
  output logic                                 sbr_rvalid_o,
  output logic                                 sbr_err_o,
  output logic [user_pkg::DataWidth-1:0]       sbr_rdata_o,
  // Interrupts to the core
  output logic [user_pkg::NumExternalIrqs-1:0] interrupts_o,
  // LED strip line
  output logic                                 neopixel_data_o
);

  logic                           rom_req;
  logic                           rom_gnt;
  logic                           rom_rvalid;
  logic [user_pkg::DataWidth-1:0] rom_rdata;
  logic                           np_req;
  logic                           np_gnt;
  logic                           np_rvalid;
  logic [user_pkg::DataWidth-1:0] np_rdata;
  logic                           np_irq;

  //--------------------------------------------------------------------------
  // Decode and response merge
  //--------------------------------------------------------------------------

  user_sbr_demux i_sbr_demux (
    .clk_i,
    .rst_n_i,
    .sbr_req_i,
    .sbr_gnt_o,
    .sbr_addr_i,
    .sbr_rvalid_o,
    .sbr_rdata_o,
    .sbr_err_o,
    .rom_req_o    ( rom_req    ),
    .rom_gnt_i    ( rom_gnt    ),
    .rom_rvalid_i ( rom_rvalid ),
    .rom_rdata_i  ( rom_rdata  ),
    .np_req_o     ( np_req     ),
    .np_gnt_i     ( np_gnt     ),
    .np_rvalid_i  ( np_rvalid  ),
    .np_rdata_i   ( np_rdata   )
  );

  //--------------------------------------------------------------------------
  // Subordinates
  //--------------------------------------------------------------------------

  // Address fans out to both
  user_rom i_rom (
    .clk_i,
    .rst_n_i,
    .req_i    ( rom_req    ),
    .addr_i   ( sbr_addr_i ),
    .gnt_o    ( rom_gnt    ),
    .rvalid_o ( rom_rvalid ),
    .rdata_o  ( rom_rdata  )
  );

  neopixel #(
    .FifoDepth   ( FifoDepth   ),
    .BitCycles   ( BitCycles   ),
    .T0hCycles   ( T0hCycles   ),
    .T1hCycles   ( T1hCycles   ),
    .ResetCycles ( ResetCycles )
  ) i_neopixel (
    .clk_i,
    .rst_n_i,
    .req_i    ( np_req          ),
    .we_i     ( sbr_we_i        ),
    .addr_i   ( sbr_addr_i      ),
    .wdata_i  ( sbr_wdata_i     ),
    .gnt_o    ( np_gnt          ),
    .rvalid_o ( np_rvalid       ),
    .rdata_o  ( np_rdata        ),
    .irq_o    ( np_irq          ),
    .data_o   ( neopixel_data_o )
  );

  // FIFO level interrupt on bit 0, rest unused
  assign interrupts_o = {{(user_pkg::NumExternalIrqs - 1){1'b0}}, np_irq};

endmodule

`default_nettype wire

// File: sim/tb_user_domain.sv
//--------------------------------------------------------------------------
// User domain testbench
// Bus traffic to ROM, NeoPixel and unmapped space, with LED line decoding
//--------------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module tb_user_domain;

  localparam int unsigned FifoDepth     = 8;
  localparam int unsigned BitCycles     = 12;
  localparam int unsigned T0hCycles     = 4;
  localparam int unsigned T1hCycles     = 8;
  localparam int unsigned ResetCycles   = 40;
  localparam int unsigned TimeoutCycles = 20000;

  localparam logic [31:0] NpBase = user_pkg::UserNeopixelBase;
  localparam logic [31:0] CtrlAddr   = NpBase + user_pkg::NpCtrlOffset;
  localparam logic [31:0] StatusAddr = NpBase + user_pkg::NpStatusOffset;
  localparam logic [31:0] DataAddr   = NpBase + user_pkg::NpDataOffset;
  localparam logic [31:0] ThreshAddr = NpBase + user_pkg::NpThreshOffset;

  logic        clk_i;
  logic        rst_n_i;
  logic        sbr_req_i;
  logic        sbr_we_i;
  logic [31:0] sbr_addr_i;
  logic [31:0] sbr_wdata_i;
  logic        sbr_gnt_o;
  logic        sbr_rvalid_o;
  logic        sbr_err_o;
  logic [31:0] sbr_rdata_o;
  logic [3:0]  interrupts_o;
  logic        neopixel_data_o;

  integer      seed = 32'hf4e9;
  int unsigned cycle_cnt = 0;
  logic        xfer_q;
  // Pixels written but not yet seen on the LED line
  logic [23:0] exp_pixels[$];
  int unsigned pixels_seen;
  int unsigned frames_seen;
  int unsigned lo_cnt;

  user_domain #(
    .FifoDepth   ( FifoDepth   ),
    .BitCycles   ( BitCycles   ),
    .T0hCycles   ( T0hCycles   ),
    .T1hCycles   ( T1hCycles   ),
    .ResetCycles ( ResetCycles )
  ) user_domain_inst (
    .clk_i,
    .rst_n_i,
    .sbr_req_i,
    .sbr_we_i,
    .sbr_addr_i,
    .sbr_wdata_i,
    .sbr_gnt_o,
    .sbr_rvalid_o,
    .sbr_err_o,
    .sbr_rdata_o,
    .interrupts_o,
    .neopixel_data_o
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  //--------------------------------------------------------------------------
  // Failure reporting and checks
  //--------------------------------------------------------------------------

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("TEST FAIL");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
    assert (exp === act) else begin
      report_failure($sformatf("[ERROR] %s: expected %h, actual %h", name, exp, act));
    end
  endtask

  // Transfer seen at each edge, response due one cycle later
  always @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      xfer_q <= 1'b0;
    end else begin
      xfer_q <= sbr_req_i && sbr_gnt_o;
    end
  end

  rvalid_follows_transfer: assert property (
    @(posedge clk_i) disable iff (!rst_n_i) sbr_rvalid_o == xfer_q
  ) else report_failure($sformatf("[ERROR] rvalid_timing: expected %b, actual %b",
                                  $sampled(xfer_q), $sampled(sbr_rvalid_o)));

  upper_irqs_zero: assert property (
    @(posedge clk_i) disable iff (!rst_n_i) interrupts_o[3:1] == 3'b000
  ) else report_failure($sformatf("[ERROR] irq_upper: expected 0, actual %h",
                                  $sampled(interrupts_o[3:1])));

  // Watchdog
  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TimeoutCycles) begin
      report_failure("Timeout: the run did not finish within the cycle limit");
    end
  end

  //--------------------------------------------------------------------------
  // LED line decoder
  //--------------------------------------------------------------------------

  initial begin
    logic        prev;
    int unsigned hi_cnt;
    int unsigned period_cnt;
    int unsigned bits;
    logic [23:0] word;
    prev        = 1'b0;
    hi_cnt      = 0;
    period_cnt  = 0;
    bits        = 0;
    word        = '0;
    pixels_seen = 0;
    frames_seen = 0;
    lo_cnt      = ResetCycles;
    forever begin
      @(posedge clk_i);
      period_cnt++;
      if (neopixel_data_o && !prev) begin
        // Rising edge starts a bit
        if (lo_cnt < ResetCycles) begin
          check_value("bit_period", BitCycles, period_cnt);
        end else begin
          check_value("frame_start_bits", 0, bits);
          frames_seen++;
        end
        period_cnt = 0;
      end
      if (!neopixel_data_o && prev) begin
        if (hi_cnt != T0hCycles && hi_cnt != T1hCycles) begin
          report_failure($sformatf("LED high pulse of %0d cycles is neither a 0 nor a 1 bit",
                                   hi_cnt));
        end
        word = {word[22:0], (hi_cnt == T1hCycles)};
        bits++;
        hi_cnt = 0;
        if (bits == 24) begin
          bits = 0;
          pixels_seen++;
          if (exp_pixels.size() == 0) begin
            report_failure("LED line sent a pixel that was never written");
          end
          check_value("pixel_data", exp_pixels.pop_front(), word);
        end
      end
      if (neopixel_data_o) begin
        hi_cnt++;
        lo_cnt = 0;
      end else begin
        lo_cnt++;
      end
      prev = neopixel_data_o;
    end
  end

  //--------------------------------------------------------------------------
  // Bus tasks
  //--------------------------------------------------------------------------

  // Starts on a falling edge and returns on the falling edge of the response
  // Calls in a row give back-to-back transfers
  task automatic bus_access(input logic [31:0] addr, input logic we,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output logic err, output int unsigned stalls);
    sbr_req_i   = 1'b1;
    sbr_addr_i  = addr;
    sbr_we_i    = we;
    sbr_wdata_i = wdata;
    stalls      = 0;
    @(posedge clk_i);
    while (!sbr_gnt_o) begin
      stalls++;
      @(posedge clk_i);
    end
    @(negedge clk_i);
    sbr_req_i = 1'b0;
    check_value("rvalid", 1, sbr_rvalid_o);
    rdata = sbr_rdata_o;
    err   = sbr_err_o;
  endtask

  task automatic reg_read(input string name, input logic [31:0] addr,
                          input logic [31:0] exp);
    logic [31:0] rdata;
    logic        err;
    int unsigned stalls;
    bus_access(addr, 1'b0, '0, rdata, err, stalls);
    check_value({name, "_err"}, 0, err);
    check_value(name, exp, rdata);
  endtask

  task automatic reg_write(input logic [31:0] addr, input logic [31:0] wdata,
                           output int unsigned stalls);
    logic [31:0] rdata;
    logic        err;
    bus_access(addr, 1'b1, wdata, rdata, err, stalls);
    check_value("write_err", 0, err);
  endtask

  task automatic pixel_write(output int unsigned stalls);
    logic [23:0] pix;
    pix = 24'($random(seed));
    exp_pixels.push_back(pix);
    reg_write(DataAddr, {8'h00, pix}, stalls);
  endtask

  // Reads on consecutive cycles, one response per cycle
  task automatic rom_burst(input int unsigned n);
    logic [31:0] addrs[$];
    logic [31:0] a;
    for (int unsigned i = 0; i <= n; i++) begin
      @(negedge clk_i);
      if (i > 0) begin
        a = addrs.pop_front();
        check_value("rom_burst_rvalid", 1, sbr_rvalid_o);
        check_value("rom_burst_err", 0, sbr_err_o);
        check_value("rom_burst_data", user_pkg::RomTable[a[4:2]], sbr_rdata_o);
      end
      if (i < n) begin
        a = user_pkg::UserRomBase | (32'($random(seed)) & 32'h0000_0FFC);
        addrs.push_back(a);
        sbr_req_i  = 1'b1;
        sbr_we_i   = 1'b0;
        sbr_addr_i = a;
      end else begin
        sbr_req_i = 1'b0;
      end
    end
  endtask

  // Poll STATUS until the FIFO is empty and the serializer idle
  task automatic wait_drained();
    logic [31:0] rdata;
    logic        err;
    int unsigned stalls;
    rdata = '0;
    while (rdata[10:8] != 3'b001) begin
      bus_access(StatusAddr, 1'b0, '0, rdata, err, stalls);
    end
  endtask

  //--------------------------------------------------------------------------
  // Stimulus
  //--------------------------------------------------------------------------

  initial begin
    logic [31:0] rdata;
    logic        err;
    int unsigned stalls;
    sbr_req_i   = 1'b0;
    sbr_we_i    = 1'b0;
    sbr_addr_i  = '0;
    sbr_wdata_i = '0;
    rst_n_i     = 1'b0;
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    rst_n_i = 1'b1;

    // Reset values
    check_value("reset_irq", 0, interrupts_o);
    reg_read("reset_ctrl", CtrlAddr, 32'h0);
    reg_read("reset_status", StatusAddr, 32'h100);
    reg_read("reset_thresh", ThreshAddr, 32'h0);

    // ROM reads, single and back to back
    for (int i = 0; i < 8; i++) begin
      rdata = user_pkg::UserRomBase | (32'($random(seed)) & 32'h0000_0FFC);
      reg_read("rom_single", rdata, user_pkg::RomTable[rdata[4:2]]);
    end
    rom_burst(16);

    // Unmapped space, the write lands on a CTRL-like offset
    bus_access(32'h3000_0000, 1'b0, '0, rdata, err, stalls);
    check_value("unmapped_read_err", 1, err);
    check_value("unmapped_read_data", user_pkg::ErrRspData, rdata);
    bus_access(32'h3000_0000, 1'b1, 32'h0000_0001, rdata, err, stalls);
    check_value("unmapped_write_err", 1, err);
    reg_read("ctrl_after_err", CtrlAddr, 32'h0);
    reg_read("rom_after_err", user_pkg::UserRomBase + 32'h8, user_pkg::RomTable[2]);

    // Register read back
    reg_write(ThreshAddr, 32'h0000_01A5, stalls);
    reg_read("thresh_rb", ThreshAddr, 32'h0000_00A5);
    reg_write(ThreshAddr, 32'h0000_0004, stalls);
    reg_read("thresh_rb2", ThreshAddr, 32'h0000_0004);

    // Fill while disabled and watch the level
    for (int unsigned n = 1; n <= FifoDepth; n++) begin
      pixel_write(stalls);
      check_value("fill_stalls", 0, stalls);
      reg_read("status_level", StatusAddr,
               {21'h0, 1'b0, (n == FifoDepth), 1'b0, 8'(n)});
      check_value("irq_disabled", 0, interrupts_o[0]);
    end

    // Enable and push in the next cycle, the push waits for the first pop
    reg_write(CtrlAddr, 32'h1, stalls);
    pixel_write(stalls);
    if (stalls == 0) begin
      report_failure("DATA write into a full FIFO was granted without back-pressure");
    end
    check_value("irq_above_thresh", 0, interrupts_o[0]);
    reg_read("ctrl_rb", CtrlAddr, 32'h1);

    wait_drained();
    check_value("latch_gap", 1, lo_cnt >= ResetCycles);
    check_value("pixels_sent", FifoDepth + 1, pixels_seen);
    check_value("pixels_left", 0, exp_pixels.size());
    check_value("frames_sent", 1, frames_seen);
    repeat (2) @(negedge clk_i);
    check_value("irq_enabled_low_level", 1, interrupts_o[0]);

    // Chained pixels after a gap, then disable
    pixel_write(stalls);
    pixel_write(stalls);
    wait_drained();
    check_value("pixels_sent2", FifoDepth + 3, pixels_seen);
    check_value("pixels_left2", 0, exp_pixels.size());
    check_value("frames_sent2", 2, frames_seen);
    reg_write(CtrlAddr, 32'h0, stalls);
    repeat (2) @(negedge clk_i);
    check_value("irq_after_disable", 0, interrupts_o[0]);

    $display("TEST PASS");
    $finish;
  end

endmodule

`default_nettype wire

// File: user_domain.f
src/user_pkg.sv
src/user_sbr_demux.sv
src/user_rom.sv
src/pixel_fifo.sv
src/neopixel_serializer.sv
src/neopixel.sv
src/user_domain.sv
sim/tb_user_domain.sv

// File: Makefile
# Verilator build for the user domain testbench

VERILATOR ?= verilator
TOP       := tb_user_domain
FILELIST  := user_domain.f
OBJ_DIR   := obj_dir
LINT_FLAGS := --lint-only --timing --top-module $(TOP)
SIM_FLAGS  := --binary --timing --assert --top-module $(TOP) -Mdir $(OBJ_DIR)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(shell cat $(FILELIST))
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST)

# A $fatal in the testbench gives a non-zero exit status
sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
